/* src/dma_rreq_pkg.sv */
package dma_rreq_pkg;

    // ************************************************
    // field widths
    // ************************************************
    localparam int axis_tuser_w = 128;                     // one header per request beat
    localparam int dw_len_w     = 11;                      // size in dwords
    localparam int chnl_w       = 8;                       // dma channel number
    localparam int dma_addr_w   = 64;                      // byte address
    localparam int req_type_w   = 4;
    localparam int be_w         = 4;                       // first_be and last_be each
    localparam int tag_fld_w    = 8;                       // tag slot in the header
    localparam int misc_addr_w  = 7;                       // low unaligned address bits per tag
    localparam int empty_w      = 5;                       // empty bytes, first plus last
    localparam int tag_misc_w   = misc_addr_w + empty_w;   // 12 bit misc context

    // ************************************************
    // header layout
    // ************************************************
    // | chnl    | last | rsvd    | type    | tag    | addr  | rsvd  | dw_len | fbe | lbe |
    // | 127:120 | 119  | 118:108 | 107:104 | 103:96 | 95:32 | 31:19 | 18:8   | 7:4 | 3:0 |
    localparam int chnl_msb     = 127;
    localparam int chnl_lsb     = 120;
    localparam int last_pos     = 119;                     // last sub-request of a split read
    localparam int req_type_msb = 107;
    localparam int req_type_lsb = 104;
    localparam int tag_msb      = 103;                     // ignored on input
    localparam int tag_lsb      = 96;
    localparam int addr_msb     = 95;                      // dword aligned
    localparam int addr_lsb     = 32;
    localparam int dw_len_msb   = 18;
    localparam int dw_len_lsb   = 8;
    localparam int first_be_msb = 7;
    localparam int first_be_lsb = 4;
    localparam int last_be_msb  = 3;
    localparam int last_be_lsb  = 0;

    // bits above the type field are cleared on the way to the link
    localparam int out_rsvd_w   = axis_tuser_w - 1 - req_type_msb;

    // ************************************************
    // request type codes
    // ************************************************
    localparam logic [req_type_w-1:0] req_type_mem_rd    = 4'b0000;  // memory read
    localparam logic [req_type_w-1:0] req_type_mem_rd_lk = 4'b0001;  // locked memory read
    localparam logic [req_type_w-1:0] req_type_io_rd     = 4'b0010;  // io read
    localparam logic [req_type_w-1:0] req_type_cfg_rd    = 4'b1000;  // config read

endpackage

/* src/tag_req_if.sv */
`timescale 1ns/1ps

interface tag_req_if import dma_rreq_pkg::*; #(
    parameter int tag_num_log = 3                  // log2 of tag count
) ();

    // ************************************************
    // request side to pool
    // ************************************************
    logic                   ready;                 // a request wants a tag now
    logic                   last;                  // last sub-request flag
    logic [dw_len_w-1:0]    sz;                    // dword length
    logic [chnl_w-1:0]      chnl;                  // owning channel
    logic [tag_misc_w-1:0]  misc;                  // addr low bits and empty bytes

    // ************************************************
    // pool to request side
    // ************************************************
    logic [tag_num_log-1:0] tag;                   // lowest free tag
    logic                   valid;                 // some tag is free

    // request side, drives the context
    modport req (
        output ready, last, sz, chnl, misc,
        input  tag, valid
    );

    // tag pool, drives the offered tag
    modport pool (
        input  ready, last, sz, chnl, misc,
        output tag, valid
    );

endinterface

/* src/st_reg.sv */
`timescale 1ns/1ps

module st_reg import dma_rreq_pkg::*; (
    input  logic                    dma_clk,
    input  logic                    rst_n,

    input  logic                    in_tvalid,
    input  logic [axis_tuser_w-1:0] in_tuser,
    output logic                    in_tready,       // from occupancy only

    output logic                    out_tvalid,
    output logic [axis_tuser_w-1:0] out_tuser,
    input  logic                    out_tready
);

    logic                    in_fire;
    logic                    out_fire;
    logic                    main_vld;               // output register holds a beat
    logic                    spare_vld;              // skid register holds a beat
    logic                    main_vld_nxt;
    logic                    spare_vld_nxt;
    logic                    main_ld;                // main takes the input beat
    logic                    main_from_spare;        // main takes the older spare beat
    logic                    spare_ld;
    logic [axis_tuser_w-1:0] main_q;
    logic [axis_tuser_w-1:0] spare_q;

    assign in_fire  = in_tvalid & in_tready;
    assign out_fire = main_vld & out_tready;

    always_comb begin
        main_vld_nxt    = main_vld;
        spare_vld_nxt   = spare_vld;
        main_ld         = 1'b0;
        main_from_spare = 1'b0;
        spare_ld        = 1'b0;
        if (!main_vld || out_fire) begin          // main frees up this cycle
            if (spare_vld) begin                  // older beat first
                main_from_spare = 1'b1;
                main_vld_nxt    = 1'b1;
                spare_vld_nxt   = 1'b0;
            end else begin
                main_ld      = in_fire;           // straight into main
                main_vld_nxt = in_fire;
            end
        end else if (in_fire) begin               // stalled, park in spare
            spare_ld      = 1'b1;
            spare_vld_nxt = 1'b1;
        end
    end

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            main_vld  <= 1'b0;
            spare_vld <= 1'b0;
            in_tready <= 1'b1;                    // empty after reset
        end else begin
            main_vld  <= main_vld_nxt;
            spare_vld <= spare_vld_nxt;
            in_tready <= ~spare_vld_nxt;          // closes once both entries fill
        end
    end

    always_ff @(posedge dma_clk) begin
        if (main_from_spare) begin
            main_q <= spare_q;
        end else if (main_ld) begin
            main_q <= in_tuser;
        end
        if (spare_ld) begin
            spare_q <= in_tuser;
        end
    end

    assign out_tvalid = main_vld;
    assign out_tuser  = main_q;

endmodule

/* src/tag_request.sv */
`timescale 1ns/1ps

module tag_request import dma_rreq_pkg::*; #(
    parameter int tag_num_log = 3
) (
    input  logic                    dma_clk,
    input  logic                    rst_n,

    // one-beat requests from the arbiter
    input  logic                    rreq_tvalid,
    input  logic [axis_tuser_w-1:0] rreq_tuser,
    output logic                    rreq_tready,

    tag_req_if.req                  tag_if,            // tag pool handshake

    // tagged requests toward the link
    output logic                    rreq_tag_tvalid,
    output logic [axis_tuser_w-1:0] rreq_tag_tuser,
    input  logic                    rreq_tag_tready
);

    logic [chnl_w-1:0]       chnl_num;
    logic                    last_sub_req;
    logic [req_type_w-1:0]   req_type;
    logic [dw_len_w-1:0]     dw_len;
    logic [dma_addr_w-1:0]   addr_align;
    logic [be_w-1:0]         first_be;
    logic [be_w-1:0]         last_be;
    logic [1:0]              first_empty;              // dead bytes in first dword
    logic [1:0]              last_empty;               // dead bytes in last dword
    logic [1:0]              first_hi;                 // top enabled byte of first_be
    logic [dma_addr_w-1:0]   addr_unalign;
    logic [empty_w-1:0]      empty;
    logic [tag_num_log-1:0]  grant_tag;
    logic                    slice_rdy;                // st_reg has room
    logic                    accept;                   // input, grant and slice write
    logic [axis_tuser_w-1:0] tagged_tuser;

    // ************************************************
    // header decode
    // ************************************************
    assign chnl_num     = rreq_tuser[chnl_msb:chnl_lsb];
    assign last_sub_req = rreq_tuser[last_pos];
    assign req_type     = rreq_tuser[req_type_msb:req_type_lsb];
    assign dw_len       = rreq_tuser[dw_len_msb:dw_len_lsb];
    assign addr_align   = rreq_tuser[addr_msb:addr_lsb];
    assign first_be     = rreq_tuser[first_be_msb:first_be_lsb];
    assign last_be      = rreq_tuser[last_be_msb:last_be_lsb];

    always_comb begin
        first_empty = 2'd0;                            // no enable set, treat as aligned
        first_hi    = 2'd0;
        for (int i = be_w - 1; i >= 0; i--) begin      // lowest set bit wins
            if (first_be[i]) begin
                first_empty = 2'(i);
            end
        end
        for (int i = 0; i < be_w; i++) begin           // highest set bit wins
            if (first_be[i]) begin
                first_hi = 2'(i);
            end
        end
    end

    always_comb begin
        if (dw_len == dw_len_w'(1)) begin              // single dword, first_be covers both ends
            last_empty = 2'd3 - first_hi;
        end else begin
            case (last_be)
                4'b1111: last_empty = 2'd0;
                4'b0111: last_empty = 2'd1;
                4'b0011: last_empty = 2'd2;
                4'b0001: last_empty = 2'd3;
                default: last_empty = 2'd0;            // not a legal pattern
            endcase
        end
    end

    assign addr_unalign = {addr_align[dma_addr_w-1:2], first_empty};    // true start byte
    assign empty        = empty_w'(first_empty) + empty_w'(last_empty);

    // ************************************************
    // tag handshake
    // ************************************************
    assign accept      = rreq_tvalid & tag_if.valid & slice_rdy;
    assign rreq_tready = accept;                       // only with a tag and room
    assign grant_tag   = tag_if.tag;

    assign tag_if.ready = accept;                      // grant happens with the transfer
    assign tag_if.last  = last_sub_req;
    assign tag_if.sz    = dw_len;
    assign tag_if.chnl  = chnl_num;
    assign tag_if.misc  = {addr_unalign[misc_addr_w-1:0], empty};

    // header toward the link, channel and last flag dropped
    assign tagged_tuser = {
        {out_rsvd_w{1'b0}},
        req_type,
        tag_fld_w'(grant_tag),                         // zero extended
        rreq_tuser[addr_msb:0]
    };

    st_reg u_st_reg (
        .dma_clk    (dma_clk),
        .rst_n      (rst_n),
        .in_tvalid  (accept),
        .in_tuser   (tagged_tuser),
        .in_tready  (slice_rdy),
        .out_tvalid (rreq_tag_tvalid),
        .out_tuser  (rreq_tag_tuser),
        .out_tready (rreq_tag_tready)
    );

endmodule

/* src/tag_alloc.sv */
`timescale 1ns/1ps

module tag_alloc import dma_rreq_pkg::*; #(
    parameter int tag_num_log = 3
) (
    input  logic                   dma_clk,
    input  logic                   rst_n,

    tag_req_if.pool                tag_if,           // grants to tag_request

    // completion lookup
    input  logic                   cpl_valid,
    input  logic [tag_num_log-1:0] cpl_tag,
    output logic                   cpl_rsp_valid,    // one cycle after cpl_valid
    output logic [dw_len_w-1:0]    cpl_rsp_sz,
    output logic [chnl_w-1:0]      cpl_rsp_chnl,
    output logic                   cpl_rsp_last,
    output logic [tag_misc_w-1:0]  cpl_rsp_misc
);

    localparam int tag_num = 1 << tag_num_log;
    localparam int ctx_w   = 1 + dw_len_w + chnl_w + tag_misc_w;   // last, sz, chnl, misc

    logic [tag_num-1:0]     busy;                    // one bit per outstanding tag
    logic [tag_num-1:0]     busy_nxt;
    logic [tag_num_log-1:0] free_tag;                // lowest free index
    logic                   any_free;
    logic                   grant;
    logic [ctx_w-1:0]       ctx_wr;
    logic [ctx_w-1:0]       ctx_mem [tag_num];       // per tag context store
    logic [ctx_w-1:0]       ctx_rsp;                 // registered lookup result

    // ************************************************
    // free tag search
    // ************************************************
    always_comb begin
        free_tag = '0;
        any_free = 1'b0;
        for (int i = tag_num - 1; i >= 0; i--) begin  // descending, so lowest sticks
            if (!busy[i]) begin
                free_tag = tag_num_log'(i);
                any_free = 1'b1;
            end
        end
    end

    assign tag_if.valid = any_free;                  // low when all tags are out
    assign tag_if.tag   = free_tag;
    assign grant        = tag_if.ready & any_free;

    // ************************************************
    // busy bitmap
    // ************************************************
    always_comb begin
        busy_nxt = busy;
        if (cpl_valid) begin
            busy_nxt[cpl_tag] = 1'b0;                // release on completion
        end
        if (grant) begin
            busy_nxt[free_tag] = 1'b1;               // never the tag being released
        end
    end

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;                              // all tags free
        end else begin
            busy <= busy_nxt;
        end
    end

    // ************************************************
    // context store and lookup
    // ************************************************
    assign ctx_wr = {tag_if.last, tag_if.sz, tag_if.chnl, tag_if.misc};

    always_ff @(posedge dma_clk) begin
        if (grant) begin
            ctx_mem[free_tag] <= ctx_wr;
        end
    end

    always_ff @(posedge dma_clk) begin
        if (cpl_valid) begin
            ctx_rsp <= ctx_mem[cpl_tag];             // read before the bit clears
        end
    end

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            cpl_rsp_valid <= 1'b0;
        end else begin
            cpl_rsp_valid <= cpl_valid;
        end
    end

    // unpack in the same order as ctx_wr
    assign cpl_rsp_last = ctx_rsp[ctx_w-1];
    assign cpl_rsp_sz   = ctx_rsp[ctx_w-2 -: dw_len_w];
    assign cpl_rsp_chnl = ctx_rsp[tag_misc_w +: chnl_w];
    assign cpl_rsp_misc = ctx_rsp[tag_misc_w-1:0];

endmodule

/* src/rd_req_tag_top.sv */
`timescale 1ns/1ps

module rd_req_tag_top import dma_rreq_pkg::*; #(
    parameter int tag_num_log = 3                    // eight tags by default
) (
    input  logic                    dma_clk,
    input  logic                    rst_n,

    // requests from the arbiter
    input  logic                    rreq_tvalid,
    input  logic [axis_tuser_w-1:0] rreq_tuser,
    output logic                    rreq_tready,

    // tagged requests toward the link
    output logic                    rreq_tag_tvalid,
    output logic [axis_tuser_w-1:0] rreq_tag_tuser,
    input  logic                    rreq_tag_tready,

    // completion lookup and tag release
    input  logic                    cpl_valid,
    input  logic [tag_num_log-1:0]  cpl_tag,
    output logic                    cpl_rsp_valid,
    output logic [dw_len_w-1:0]     cpl_rsp_sz,
    output logic [chnl_w-1:0]       cpl_rsp_chnl,
    output logic                    cpl_rsp_last,
    output logic [tag_misc_w-1:0]   cpl_rsp_misc
);

    // ************************************************
    // tag channel
    // ************************************************
    tag_req_if #(.tag_num_log(tag_num_log)) u_tag_if ();

    tag_request #(.tag_num_log(tag_num_log)) u_tag_request (
        .dma_clk         (dma_clk),
        .rst_n           (rst_n),
        .rreq_tvalid     (rreq_tvalid),
        .rreq_tuser      (rreq_tuser),
        .rreq_tready     (rreq_tready),
        .tag_if          (u_tag_if.req),
        .rreq_tag_tvalid (rreq_tag_tvalid),
        .rreq_tag_tuser  (rreq_tag_tuser),
        .rreq_tag_tready (rreq_tag_tready)
    );

    tag_alloc #(.tag_num_log(tag_num_log)) u_tag_alloc (
        .dma_clk       (dma_clk),
        .rst_n         (rst_n),
        .tag_if        (u_tag_if.pool),
        .cpl_valid     (cpl_valid),
        .cpl_tag       (cpl_tag),
        .cpl_rsp_valid (cpl_rsp_valid),
        .cpl_rsp_sz    (cpl_rsp_sz),
        .cpl_rsp_chnl  (cpl_rsp_chnl),
        .cpl_rsp_last  (cpl_rsp_last),
        .cpl_rsp_misc  (cpl_rsp_misc)
    );

endmodule

/* testbench/rd_req_tag_asserts.sv */
`timescale 1ns/1ps

module rd_req_tag_asserts import dma_rreq_pkg::*; #(
    parameter int tag_num_log = 3
) (
    input logic                          dma_clk,
    input logic                          rst_n,
    input logic                          tvalid,       // stream under watch
    input logic                          tready,
    input logic [axis_tuser_w-1:0]       tuser,
    input logic                          grant,        // pool side
    input logic [tag_num_log-1:0]        grant_tag,
    input logic [(1 << tag_num_log)-1:0] busy,
    input logic                          cpl_valid,
    input logic [tag_num_log-1:0]        cpl_tag
);

    int fail_cnt = 0;
    logic [(1 << tag_num_log)-1:0] issued;             // tags granted and not yet completed

    // shadow of the outstanding tags
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            issued <= '0;
        end else begin
            if (cpl_valid) begin
                issued[cpl_tag] <= 1'b0;
            end
            if (grant) begin
                issued[grant_tag] <= 1'b1;
            end
        end
    end

    // ************************************************
    // stream stall
    // ************************************************
    stall_hold: assert property (@(posedge dma_clk) disable iff (!rst_n)
        tvalid && !tready |=> tvalid && $stable(tuser))
        else begin
            $error("stalled beat dropped or changed");
            fail_cnt++;
        end

    // ************************************************
    // tag pool
    // ************************************************
    grant_free: assert property (@(posedge dma_clk) disable iff (!rst_n)
        grant |-> !issued[grant_tag])                  // no tag handed out twice
        else begin
            $error("granted tag %0d was still outstanding", grant_tag);
            fail_cnt++;
        end

    cpl_busy: assert property (@(posedge dma_clk) disable iff (!rst_n)
        cpl_valid |-> busy[cpl_tag])
        else begin
            $error("completion for free tag %0d", cpl_tag);
            fail_cnt++;
        end

endmodule

// output side of the slice
bind tag_request rd_req_tag_asserts #(.tag_num_log(tag_num_log)) u_req_asserts (
    .dma_clk   (dma_clk),
    .rst_n     (rst_n),
    .tvalid    (rreq_tag_tvalid),
    .tready    (rreq_tag_tready),
    .tuser     (rreq_tag_tuser),
    .grant     (1'b0),
    .grant_tag ('0),
    .busy      ('0),
    .cpl_valid (1'b0),
    .cpl_tag   ('0)
);

bind tag_alloc rd_req_tag_asserts #(.tag_num_log(tag_num_log)) u_alloc_asserts (
    .dma_clk   (dma_clk),
    .rst_n     (rst_n),
    .tvalid    (1'b0),
    .tready    (1'b1),
    .tuser     ('0),
    .grant     (grant),
    .grant_tag (free_tag),
    .busy      (busy),
    .cpl_valid (cpl_valid),
    .cpl_tag   (cpl_tag)
);

/* testbench/tb_rd_req_tag.sv */
`timescale 1ns/1ps

module tb_rd_req_tag import dma_rreq_pkg::*; ();

    localparam int tag_num_log = 3;
    localparam int tag_num     = 1 << tag_num_log;
    localparam int num_req     = 9;                     // eight fill the pool and one more waits
    localparam int max_wait    = 200;                   // cycles per wait loop

    typedef struct {
        logic [chnl_w-1:0]     chnl;
        logic [req_type_w-1:0] req_type;
        logic [dma_addr_w-1:0] addr;                    // dword aligned
        logic [dw_len_w-1:0]   dw_len;
        logic [3:0]            first_be;
        logic [3:0]            last_be;
        logic                  last;
        logic [tag_misc_w-1:0] misc;                    // {addr[6:2], first_empty, empty}
    } req_entry_t;

    logic                    dma_clk;
    logic                    rst_n;
    logic                    rreq_tvalid;
    logic [axis_tuser_w-1:0] rreq_tuser;
    logic                    rreq_tready;
    logic                    rreq_tag_tvalid;
    logic [axis_tuser_w-1:0] rreq_tag_tuser;
    logic                    rreq_tag_tready;
    logic                    cpl_valid;
    logic [tag_num_log-1:0]  cpl_tag;
    logic                    cpl_rsp_valid;
    logic [dw_len_w-1:0]     cpl_rsp_sz;
    logic [chnl_w-1:0]       cpl_rsp_chnl;
    logic                    cpl_rsp_last;
    logic [tag_misc_w-1:0]   cpl_rsp_misc;

    req_entry_t              req_tbl [num_req];
    req_entry_t              tag_ctx [tag_num];        // model context per tag
    bit                      tag_busy [tag_num];       // model busy bitmap
    logic [axis_tuser_w-1:0] exp_q [$];                // link headers in expected order
    logic [31:0]             lfsr;

    rd_req_tag_top #(.tag_num_log(tag_num_log)) u_dut (.*);

    initial begin
        dma_clk = 1'b0;
        forever #4 dma_clk = ~dma_clk;                  // 8 ns period
    end

    // ************************************************
    // helpers
    // ************************************************
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic int busy_count();
        int c;
        c = 0;
        foreach (tag_busy[i]) begin
            c += int'(tag_busy[i]);
        end
        return c;
    endfunction

    function automatic int failed_assertions();
        return u_dut.u_tag_request.u_req_asserts.fail_cnt
             + u_dut.u_tag_alloc.u_alloc_asserts.fail_cnt;
    endfunction

    // ************************************************
    // stimulus table with misc worked out by hand
    // ************************************************
    task automatic fill_table();
        req_tbl[0] = '{8'h03, req_type_mem_rd, 64'h1_0000_1000, 11'd16,
                       4'b1111, 4'b1111, 1'b1, {5'h00, 2'd0, 5'd0}};     // fully aligned
        req_tbl[1] = '{8'h11, req_type_mem_rd, 64'hdead_be04, 11'd4,
                       4'b1110, 4'b0111, 1'b0, {5'h01, 2'd1, 5'd2}};
        req_tbl[2] = '{8'h2a, req_type_mem_rd_lk, 64'h2078, 11'd1,
                       4'b0110, 4'b0000, 1'b1, {5'h1e, 2'd1, 5'd2}};      // one dword middle bytes
        req_tbl[3] = '{8'h05, req_type_io_rd, 64'h0040, 11'd1,
                       4'b1000, 4'b0000, 1'b1, {5'h10, 2'd3, 5'd3}};      // one dword top byte
        req_tbl[4] = '{8'h7f, req_type_cfg_rd, 64'h010c, 11'd1,
                       4'b0001, 4'b0000, 1'b0, {5'h03, 2'd0, 5'd3}};      // one dword low byte
        req_tbl[5] = '{8'h80, req_type_mem_rd, 64'h1234_5678_9abc_def0, 11'd32,
                       4'b1100, 4'b0011, 1'b1, {5'h1c, 2'd2, 5'd4}};
        req_tbl[6] = '{8'hc4, req_type_mem_rd, 64'hff_0000_0a5c, 11'd2,
                       4'b1000, 4'b0001, 1'b0, {5'h17, 2'd3, 5'd6}};      // worst case empties
        req_tbl[7] = '{8'h01, req_type_mem_rd, 64'h3ffc, 11'd1024,
                       4'b1111, 4'b0111, 1'b1, {5'h1f, 2'd0, 5'd1}};
        req_tbl[8] = '{8'h99, req_type_mem_rd, 64'h0024, 11'd1,
                       4'b0100, 4'b0000, 1'b1, {5'h09, 2'd2, 5'd3}};
    endtask

    // ************************************************
    // request and completion drivers
    // ************************************************
    task automatic send_req(input int idx);
        req_entry_t              e;
        logic [axis_tuser_w-1:0] hdr;
        logic [axis_tuser_w-1:0] exp_hdr;
        int                      waited;
        int                      t;
        e   = req_tbl[idx];
        hdr = {e.chnl, e.last, 11'h5a5, e.req_type, 8'hee, e.addr,   // junk rsvd and stale tag
               13'd0, e.dw_len, e.first_be, e.last_be};
        rreq_tuser  = hdr;
        rreq_tvalid = 1'b1;
        waited      = 0;
        do begin
            @(posedge dma_clk);
            waited++;
            if (waited > max_wait) begin
                abort_run($sformatf("request %0d was never accepted", idx));
            end
        end while (!rreq_tready);
        t = -1;
        for (int i = tag_num - 1; i >= 0; i--) begin    // lowest free tag wins
            if (!tag_busy[i]) begin
                t = i;
            end
        end
        if (t < 0) begin
            abort_run("request accepted while every tag was busy");
        end
        tag_busy[t]      = 1'b1;
        tag_ctx[t]       = e;
        exp_hdr          = hdr;
        exp_hdr[127:108] = '0;                          // chnl, last and rsvd dropped
        exp_hdr[103:96]  = 8'(t);
        exp_q.push_back(exp_hdr);
        #1;
        rreq_tvalid = 1'b0;
    endtask

    task automatic complete_one();
        int         open_tags [$];
        int         t;
        req_entry_t e;
        foreach (tag_busy[i]) begin
            if (tag_busy[i]) begin
                open_tags.push_back(i);
            end
        end
        if (open_tags.size() == 0) begin
            abort_run("no outstanding tag left to complete");
        end
        t         = open_tags[rand_bits(3) % open_tags.size()];   // random order
        e         = tag_ctx[t];
        cpl_valid = 1'b1;
        cpl_tag   = tag_num_log'(t);
        @(posedge dma_clk);
        tag_busy[t] = 1'b0;                             // grantable from the next cycle
        #1;
        cpl_valid = 1'b0;
        @(posedge dma_clk);                             // response one cycle later
        check_val("cpl_rsp_valid", 1, cpl_rsp_valid);
        check_val($sformatf("cpl_rsp_sz tag %0d", t), e.dw_len, cpl_rsp_sz);
        check_val($sformatf("cpl_rsp_chnl tag %0d", t), e.chnl, cpl_rsp_chnl);
        check_val($sformatf("cpl_rsp_last tag %0d", t), e.last, cpl_rsp_last);
        check_val($sformatf("cpl_rsp_misc tag %0d", t), e.misc, cpl_rsp_misc);
        #1;
    endtask

    // ************************************************
    // link side
    // ************************************************
    initial begin : back_pressure
        int b;
        forever begin
            @(posedge dma_clk);
            b = rand_bits(1);                           // tready for the coming cycle
            #1;
            rreq_tag_tready = b[0];
        end
    end

    always @(posedge dma_clk) begin : out_monitor
        logic [axis_tuser_w-1:0] exp_hdr;
        if (rst_n && rreq_tag_tvalid && rreq_tag_tready) begin
            if (exp_q.size() == 0) begin
                abort_run("output beat with no request pending");
            end
            exp_hdr = exp_q.pop_front();
            check_val("rreq_tag_tuser", exp_hdr, rreq_tag_tuser);
        end
    end

    always @(negedge dma_clk) begin
        if (failed_assertions() != 0) begin
            abort_run("a bound assertion failed");
        end
    end

    initial begin : main_seq
        int waited;
        rst_n           = 1'b0;
        rreq_tvalid     = 1'b0;
        rreq_tuser      = '0;
        rreq_tag_tready = 1'b0;
        cpl_valid       = 1'b0;
        cpl_tag         = '0;
        lfsr            = 32'h2e30;
        fill_table();
        repeat (10) @(posedge dma_clk);
        #1;
        rst_n = 1'b1;
        check_val("rreq_tag_tvalid after reset", 0, rreq_tag_tvalid);
        check_val("cpl_rsp_valid after reset", 0, cpl_rsp_valid);
        for (int i = 0; i < tag_num; i++) begin         // tags 0 to 7 in order
            send_req(i);
        end
        fork
            send_req(tag_num);                          // pool empty so this one waits
            begin
                repeat (20) begin
                    @(posedge dma_clk);
                    check_val("ninth request held", 0, rreq_tready);
                end
                #1;
                complete_one();
            end
        join
        while (busy_count() > 0) begin
            complete_one();
        end
        for (int i = 0; i < num_req; i++) begin         // second pass reusing freed tags
            if (busy_count() >= 4) begin
                complete_one();
            end
            send_req(i);
        end
        while (busy_count() > 0) begin
            complete_one();
        end
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge dma_clk);
            waited++;
            if (waited > max_wait) begin
                abort_run("output stream did not drain");
            end
        end
        if (failed_assertions() != 0) begin
            abort_run("a bound assertion failed");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

/* list.f */
src/dma_rreq_pkg.sv
src/tag_req_if.sv
src/st_reg.sv
src/tag_request.sv
src/tag_alloc.sv
src/rd_req_tag_top.sv
testbench/rd_req_tag_asserts.sv
testbench/tb_rd_req_tag.sv
